// ==== azadi_boot_pkg.sv ====
package azadi_boot_pkg;

  // Instruction word geometry
  localparam int unsigned DATA_W         = 32;
  localparam int unsigned BYTE_W         = 8;
  localparam int unsigned BYTES_PER_WORD = DATA_W / BYTE_W;

  // Default ICCM depth is 4096 words
  localparam int unsigned DEFAULT_ICCM_AW = 12;

  // Serial bit time in clock cycles
  localparam int unsigned DEFAULT_CLKS_PER_BIT = 87;

  // Word that ends a program download, never written to the ICCM
  localparam logic [DATA_W-1:0] END_WORD = 32'h0000_0FFF;

  // One byte off the serial line
  typedef logic [BYTE_W-1:0] byte_t;

  // Same 32 bits seen as bytes while assembling and as a word once complete
  // Byte 0 is the least significant byte
  typedef union packed {
    byte_t [BYTES_PER_WORD-1:0] bytes;
    logic  [DATA_W-1:0]         word;
  } iccm_word_u;

endpackage

// ==== azadi_boot_properties.sv ====
`timescale 1ns/1ps

module azadi_boot_properties (
  input logic clock,
  input logic reset_i,
  input logic fetch_req_i,
  input logic fetch_valid_i,
  input logic core_reset_i
);

  int unsigned fail_cnt = 0;

  // Each request answered exactly one cycle later
  property p_valid_after_req;
    @(posedge clock) disable iff (reset_i)
      fetch_req_i |=> fetch_valid_i;
  endproperty

  property p_no_valid_without_req;
    @(posedge clock) disable iff (reset_i)
      !fetch_req_i |=> !fetch_valid_i;
  endproperty

  property p_core_reset_in_reset;
    @(posedge clock) reset_i |-> core_reset_i;
  endproperty

  // Once released the core stays out of reset
  property p_core_reset_no_rise;
    @(posedge clock) disable iff (reset_i)
      !core_reset_i |=> !core_reset_i;
  endproperty

  a_valid_after_req: assert property (p_valid_after_req)
    else begin
      fail_cnt++;
      $error("fetch_valid_o missing one cycle after a fetch request");
    end
  a_no_valid_without_req: assert property (p_no_valid_without_req)
    else begin
      fail_cnt++;
      $error("fetch_valid_o high without a fetch request");
    end
  a_core_reset_in_reset: assert property (p_core_reset_in_reset)
    else begin
      fail_cnt++;
      $error("core_reset_o low while reset_i is high");
    end
  a_core_reset_no_rise: assert property (p_core_reset_no_rise)
    else begin
      fail_cnt++;
      $error("core_reset_o rose while reset_i is low");
    end

endmodule

bind azadi_boot_top azadi_boot_properties u_boot_props (
  .clock         (clock),
  .reset_i       (reset_i),
  .fetch_req_i   (fetch_req_i),
  .fetch_valid_i (fetch_valid_o),
  .core_reset_i  (core_reset_o)
);

// ==== azadi_boot_top.sv ====
`timescale 1ns/1ps

module azadi_boot_top #(
  parameter int unsigned ICCM_AW      = azadi_boot_pkg::DEFAULT_ICCM_AW,
  parameter int unsigned CLKS_PER_BIT = azadi_boot_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                              clock,
  input  logic                              reset_i,
  input  logic                              uart_rx_i,
  input  logic                              fetch_req_i,
  input  logic [ICCM_AW-1:0]                fetch_addr_i,
  output logic [azadi_boot_pkg::DATA_W-1:0] fetch_data_o,
  output logic                              fetch_valid_o,
  output logic                              core_reset_o
);

  // Receiver to loader
  logic                  rx_valid;
  azadi_boot_pkg::byte_t rx_byte;

  // Loader to ICCM
  logic                              wr_en;
  logic [ICCM_AW-1:0]                wr_addr;
  logic [azadi_boot_pkg::DATA_W-1:0] wr_data;

  uart_byte_receiver #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .clock       (clock),
    .reset_i     (reset_i),
    .rx_serial_i (uart_rx_i),
    .rx_valid_o  (rx_valid),
    .rx_byte_o   (rx_byte)
  );

  iccm_loader #(
    .ICCM_AW (ICCM_AW)
  ) u_loader (
    .clock        (clock),
    .reset_i      (reset_i),
    .rx_valid_i   (rx_valid),
    .rx_byte_i    (rx_byte),
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .core_reset_o (core_reset_o)
  );

  iccm_memory #(
    .ICCM_AW (ICCM_AW)
  ) u_iccm (
    .clock         (clock),
    .reset_i       (reset_i),
    .wr_en_i       (wr_en),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_data_o  (fetch_data_o),
    .fetch_valid_o (fetch_valid_o)
  );

endmodule

// ==== iccm_loader.sv ====
`timescale 1ns/1ps

module iccm_loader #(
  parameter int unsigned ICCM_AW = azadi_boot_pkg::DEFAULT_ICCM_AW
) (
  input  logic                              clock,
  input  logic                              reset_i,
  input  logic                              rx_valid_i,
  input  azadi_boot_pkg::byte_t             rx_byte_i,
  output logic                              wr_en_o,
  output logic [ICCM_AW-1:0]                wr_addr_o,
  output logic [azadi_boot_pkg::DATA_W-1:0] wr_data_o,
  output logic                              core_reset_o
);

  localparam int unsigned IDX_W = $clog2(azadi_boot_pkg::BYTES_PER_WORD);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(azadi_boot_pkg::BYTES_PER_WORD - 1);

  logic [IDX_W-1:0]           byte_idx;
  azadi_boot_pkg::iccm_word_u word_q;
  azadi_boot_pkg::iccm_word_u word_next;
  logic                       load_done;
  logic                       byte_take;
  logic                       word_full;
  logic                       is_end;

  // Bytes are dropped once the end marker has been seen
  assign byte_take = rx_valid_i & ~load_done;
  assign word_full = byte_take & (byte_idx == IDX_LAST);

  // Word as it looks with the incoming byte dropped in place
  always_comb begin
    word_next                 = word_q;
    word_next.bytes[byte_idx] = rx_byte_i;
  end

  assign is_end = (word_next.word == azadi_boot_pkg::END_WORD);

  always_ff @(posedge clock) begin
    if (byte_take) begin
      word_q <= word_next;
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      byte_idx  <= '0;
      load_done <= 1'b0;
      wr_en_o   <= 1'b0;
      wr_addr_o <= '0;
    end else begin
      wr_en_o <= 1'b0;
      // Step to the next word once the current one is written
      if (wr_en_o) begin
        wr_addr_o <= wr_addr_o + 1'b1;
      end
      if (byte_take) begin
        byte_idx <= byte_idx + 1'b1;
      end
      if (word_full) begin
        if (is_end) begin
          load_done <= 1'b1;
        end else begin
          wr_en_o <= 1'b1;
        end
      end
    end
  end

  // word_q holds the full word in the write cycle, the next byte is a whole
  // frame away
  assign wr_data_o = word_q.word;

  // Core is held in reset with the system and until the program is in
  assign core_reset_o = reset_i | ~load_done;

endmodule

// ==== iccm_memory.sv ====
`timescale 1ns/1ps

module iccm_memory #(
  parameter int unsigned ICCM_AW = azadi_boot_pkg::DEFAULT_ICCM_AW
) (
  input  logic                              clock,
  input  logic                              reset_i,
  input  logic                              wr_en_i,
  input  logic [ICCM_AW-1:0]                wr_addr_i,
  input  logic [azadi_boot_pkg::DATA_W-1:0] wr_data_i,
  input  logic                              fetch_req_i,
  input  logic [ICCM_AW-1:0]                fetch_addr_i,
  output logic [azadi_boot_pkg::DATA_W-1:0] fetch_data_o,
  output logic                              fetch_valid_o
);

  localparam int unsigned DEPTH = 2 ** ICCM_AW;

  logic [azadi_boot_pkg::DATA_W-1:0] mem_q [DEPTH];

  // Loader write port
  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Fetch read, data one cycle after the request
  // A write in the same cycle is seen by the next fetch only
  always_ff @(posedge clock) begin
    if (fetch_req_i) begin
      fetch_data_o <= mem_q[fetch_addr_i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      fetch_valid_o <= 1'b0;
    end else begin
      fetch_valid_o <= fetch_req_i;
    end
  end

endmodule

// ==== sim.f ====
azadi_boot_pkg.sv
uart_byte_receiver.sv
iccm_loader.sv
iccm_memory.sv
azadi_boot_top.sv
azadi_boot_properties.sv
tb_azadi_boot.sv

// ==== tb_azadi_boot.sv ====
`timescale 1ns/1ps

module tb_azadi_boot;

  localparam int unsigned TB_CLKS_PER_BIT = 16;
  localparam int unsigned ICCM_AW         = azadi_boot_pkg::DEFAULT_ICCM_AW;
  localparam int unsigned WORD_BYTES      = azadi_boot_pkg::BYTES_PER_WORD;
  localparam int unsigned RESET_CYCLES    = 8;
  localparam int unsigned LOAD_WORDS      = 20;
  localparam int unsigned SHORT_WORDS     = 5;
  localparam int unsigned IGNORED_BYTES   = 8;
  localparam int unsigned PARTIAL_BYTES   = 3;
  localparam int unsigned BAD_BYTE_POS    = 37;
  localparam int unsigned RAND_FETCHES    = 20;
  localparam int unsigned MAX_WORDS       = 32;
  localparam logic [31:0] RAND_SEED       = 32'he4c3_a82b;
  localparam int unsigned BYTE_CYCLES     = 10 * TB_CLKS_PER_BIT;

  // Bytes on the line per load
  // The second load adds a bad frame and a pad byte
  localparam int unsigned BYTES_LOAD1    = (LOAD_WORDS + 1) * WORD_BYTES;
  localparam int unsigned BYTES_LOAD2    = (LOAD_WORDS + 1) * WORD_BYTES + 1;
  localparam int unsigned BYTES_LOAD3    = IGNORED_BYTES + PARTIAL_BYTES
                                           + (SHORT_WORDS + 1) * WORD_BYTES;
  localparam int unsigned TOTAL_FETCHES  = 3 * LOAD_WORDS + SHORT_WORDS + RAND_FETCHES;
  localparam int unsigned TIMEOUT_CYCLES = (BYTES_LOAD1 + BYTES_LOAD2 + BYTES_LOAD3) * BYTE_CYCLES
                                           + 2 * TOTAL_FETCHES + 2000;

  logic                              clock;
  logic                              reset;
  logic                              uart_rx;
  logic                              fetch_req;
  logic [ICCM_AW-1:0]                fetch_addr;
  logic [azadi_boot_pkg::DATA_W-1:0] fetch_data;
  logic                              fetch_valid;
  logic                              core_reset;

  azadi_boot_pkg::byte_t tx_bytes[$];
  bit                    tx_good[$];
  logic [31:0]           exp_words [MAX_WORDS];
  logic [31:0]           ref_mem [LOAD_WORDS];
  logic [31:0]           exp_fetch_q[$];
  int                    exp_addr_q[$];
  logic [31:0]           want_word;
  int                    want_addr;
  int                    cycle_cnt = 0;

  azadi_boot_top #(
    .CLKS_PER_BIT (TB_CLKS_PER_BIT)
  ) i_azadi_boot_top (
    .clock         (clock),
    .reset_i       (reset),
    .uart_rx_i     (uart_rx),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .fetch_data_o  (fetch_data),
    .fetch_valid_o (fetch_valid),
    .core_reset_o  (core_reset)
  );

  always #5 clock = ~clock;

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_on_error($sformatf("Timeout, run still going after %0d cycles", cycle_cnt));
    end
  end

  // Concurrent checks bound into the DUT
  always @(negedge clock) begin
    assert (i_azadi_boot_top.u_boot_props.fail_cnt == 0)
      else stop_on_error("A bound property of the boot path failed");
  end

  // Every response is matched against the oldest outstanding fetch
  always @(negedge clock) begin
    if (fetch_valid === 1'b1) begin
      assert (exp_fetch_q.size() != 0)
        else stop_on_error("fetch_valid_o is high with no fetch outstanding");
      if (exp_fetch_q.size() != 0) begin
        want_word = exp_fetch_q.pop_front();
        want_addr = exp_addr_q.pop_front();
        assert (fetch_data === want_word)
          else stop_on_error($sformatf("Mismatch fetch_data_o addr %0d expected %08h actual %08h",
                                       want_addr, want_word, fetch_data));
      end
    end
  end

  // Loader rule applied to the byte stream
  // Bad frames never reach the loader
  function automatic int expected_load(input azadi_boot_pkg::byte_t stream[$],
                                       input bit good[$], output bit done);
    azadi_boot_pkg::iccm_word_u w;
    int idx;
    int count;
    int i;
    w     = '0;
    idx   = 0;
    count = 0;
    done  = 1'b0;
    for (i = 0; i < stream.size(); i++) begin
      if (good[i] && !done) begin
        w.bytes[idx] = stream[i];
        if (idx == WORD_BYTES - 1) begin
          idx = 0;
          if (w.word == azadi_boot_pkg::END_WORD) begin
            done = 1'b1;
          end else if (count < MAX_WORDS) begin
            exp_words[count] = w.word;
            count++;
          end
        end else begin
          idx++;
        end
      end
    end
    return count;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    do begin
      w = $urandom();
    end while (w == azadi_boot_pkg::END_WORD);
    return w;
  endfunction

  task automatic apply_reset();
    int i;
    @(posedge clock);
    reset <= 1'b1;
    for (i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clock);
      if (i == RESET_CYCLES - 1) begin
        reset <= 1'b0;
      end
      @(negedge clock);
      assert (core_reset === 1'b1) else stop_on_error("core_reset_o is low during reset");
      assert (fetch_valid === 1'b0) else stop_on_error("fetch_valid_o is not low during reset");
    end
    @(negedge clock);
    assert (core_reset === 1'b1) else stop_on_error("core_reset_o is low right after reset");
    assert (fetch_valid === 1'b0) else stop_on_error("fetch_valid_o is not low after reset");
  endtask

  task automatic drive_bit(input logic level);
    @(posedge clock);
    uart_rx <= level;
    repeat (TB_CLKS_PER_BIT - 1) @(posedge clock);
  endtask

  task automatic send_byte(input azadi_boot_pkg::byte_t data, input bit good_stop);
    int b;
    drive_bit(1'b0);
    for (b = 0; b < azadi_boot_pkg::BYTE_W; b++) begin
      drive_bit(data[b]);
    end
    drive_bit(good_stop);
    // Receiver rearms only once the line is back high
    if (!good_stop) begin
      drive_bit(1'b1);
    end
  endtask

  task automatic clear_stream();
    tx_bytes.delete();
    tx_good.delete();
  endtask

  task automatic push_byte(input azadi_boot_pkg::byte_t data, input bit good_stop);
    tx_bytes.push_back(data);
    tx_good.push_back(good_stop);
  endtask

  // Least significant byte goes out first
  task automatic push_word(input logic [31:0] word);
    azadi_boot_pkg::iccm_word_u u;
    int b;
    u.word = word;
    for (b = 0; b < WORD_BYTES; b++) begin
      push_byte(u.bytes[b], 1'b1);
    end
  endtask

  task automatic send_stream();
    int i;
    for (i = 0; i < tx_bytes.size(); i++) begin
      send_byte(tx_bytes[i], tx_good[i]);
    end
  endtask

  task automatic store_expected(input int count, input bit done, input int want);
    int i;
    assert (done) else stop_on_error("Reference load never reaches the end marker");
    assert (count == want)
      else stop_on_error($sformatf("Reference load holds %0d words, %0d planned", count, want));
    for (i = 0; i < count; i++) begin
      ref_mem[i] = exp_words[i];
    end
  endtask

  task automatic wait_core_release();
    int cnt;
    cnt = 0;
    while (core_reset !== 1'b0 && cnt < BYTE_CYCLES) begin
      @(negedge clock);
      cnt++;
    end
    assert (core_reset === 1'b0)
      else stop_on_error("core_reset_o still high one byte time after the end marker");
  endtask

  task automatic issue_fetch(input int addr);
    @(posedge clock);
    fetch_req  <= 1'b1;
    fetch_addr <= ICCM_AW'(addr);
    exp_fetch_q.push_back(ref_mem[addr]);
    exp_addr_q.push_back(addr);
  endtask

  task automatic drain_fetches();
    int cnt;
    @(posedge clock);
    fetch_req <= 1'b0;
    cnt = 0;
    while (exp_fetch_q.size() != 0 && cnt < 4) begin
      @(posedge clock);
      cnt++;
    end
    assert (exp_fetch_q.size() == 0) else stop_on_error("A fetch request got no response");
  endtask

  task automatic fetch_words(input int first, input int count);
    int a;
    for (a = first; a < first + count; a++) begin
      issue_fetch(a);
    end
    drain_fetches();
  endtask

  initial begin
    int  count;
    bit  done;
    int  i;
    clock      = 1'b0;
    reset      = 1'b1;
    uart_rx    = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    void'($urandom(RAND_SEED));

    apply_reset();

    // Full program followed by the end marker
    clear_stream();
    for (i = 0; i < LOAD_WORDS; i++) begin
      push_word(random_word());
    end
    push_word(azadi_boot_pkg::END_WORD);
    count = expected_load(tx_bytes, tx_good, done);
    store_expected(count, done, LOAD_WORDS);
    send_stream();
    wait_core_release();
    fetch_words(0, LOAD_WORDS);

    // One frame error
    // The pad byte restores word alignment
    apply_reset();
    clear_stream();
    for (i = 0; i < LOAD_WORDS; i++) begin
      push_word(random_word());
    end
    tx_good[BAD_BYTE_POS] = 1'b0;
    push_byte(8'($urandom()), 1'b1);
    push_word(azadi_boot_pkg::END_WORD);
    count = expected_load(tx_bytes, tx_good, done);
    store_expected(count, done, LOAD_WORDS);
    send_stream();
    wait_core_release();
    fetch_words(0, LOAD_WORDS);

    // Traffic after the end marker
    clear_stream();
    for (i = 0; i < IGNORED_BYTES; i++) begin
      push_byte(8'($urandom()), 1'b1);
    end
    send_stream();
    assert (core_reset === 1'b0) else stop_on_error("core_reset_o rose after the end marker");
    fetch_words(0, LOAD_WORDS);

    // Partial word cut off by reset and a short program after it
    apply_reset();
    clear_stream();
    for (i = 0; i < PARTIAL_BYTES; i++) begin
      push_byte(8'($urandom()), 1'b1);
    end
    send_stream();
    apply_reset();
    clear_stream();
    for (i = 0; i < SHORT_WORDS; i++) begin
      push_word(random_word());
    end
    push_word(azadi_boot_pkg::END_WORD);
    count = expected_load(tx_bytes, tx_good, done);
    store_expected(count, done, SHORT_WORDS);
    send_stream();
    wait_core_release();
    fetch_words(0, SHORT_WORDS);

    // Back to back fetches anywhere in the loaded range
    for (i = 0; i < RAND_FETCHES; i++) begin
      issue_fetch($urandom_range(LOAD_WORDS - 1, 0));
    end
    drain_fetches();

    @(negedge clock);
    if (i_azadi_boot_top.u_boot_props.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      stop_on_error("A bound property of the boot path failed");
    end
  end

endmodule

// ==== uart_byte_receiver.sv ====
`timescale 1ns/1ps

module uart_byte_receiver #(
  parameter int unsigned CLKS_PER_BIT = azadi_boot_pkg::DEFAULT_CLKS_PER_BIT
) (
  input  logic                  clock,
  input  logic                  reset_i,
  input  logic                  rx_serial_i,
  output logic                  rx_valid_o,
  output azadi_boot_pkg::byte_t rx_byte_o
);

  localparam int unsigned CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam int unsigned IDX_W = $clog2(azadi_boot_pkg::BYTE_W);

  // Last cycle of a bit, and the middle of the start bit
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(azadi_boot_pkg::BYTE_W - 1);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_START = 2'd1;
  localparam logic [1:0] ST_DATA  = 2'd2;
  localparam logic [1:0] ST_STOP  = 2'd3;

  logic                  rx_meta;
  logic                  rx_sync;
  logic [1:0]            state;
  logic [CNT_W-1:0]      bit_cnt;
  logic [IDX_W-1:0]      bit_idx;
  logic                  wait_high;
  logic                  sample_data;
  azadi_boot_pkg::byte_t shift_q;

  // Two-flop synchronizer, line idles high
  always_ff @(posedge clock) begin
    if (reset_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_serial_i;
      rx_sync <= rx_meta;
    end
  end

  assign sample_data = (state == ST_DATA) && (bit_cnt == CNT_LAST);

  always_ff @(posedge clock) begin
    if (reset_i) begin
      state      <= ST_IDLE;
      bit_cnt    <= '0;
      bit_idx    <= '0;
      wait_high  <= 1'b0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          bit_cnt <= '0;
          bit_idx <= '0;
          // After a bad stop bit the line has to go high again first
          if (rx_sync) begin
            wait_high <= 1'b0;
          end else if (!wait_high) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          if (bit_cnt == CNT_HALF) begin
            bit_cnt <= '0;
            // Low in mid start bit means a real start, else a glitch
            state   <= rx_sync ? ST_IDLE : ST_DATA;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_DATA: begin
          if (bit_cnt == CNT_LAST) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_LAST) begin
              state <= ST_STOP;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        ST_STOP: begin
          if (bit_cnt == CNT_LAST) begin
            bit_cnt <= '0;
            state   <= ST_IDLE;
            // Frame error drops the byte
            if (rx_sync) begin
              rx_valid_o <= 1'b1;
            end else begin
              wait_high <= 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clock) begin
    if (sample_data) begin
      shift_q <= {rx_sync, shift_q[azadi_boot_pkg::BYTE_W-1:1]};
    end
  end

  assign rx_byte_o = shift_q;

endmodule
